//--- Makefile
# Verilator flow for the MAC processing element

VERILATOR  ?= verilator
TOP        ?= tb_mac_pe
RTL_TOP    ?= mac_pe
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

ALL_SRCS := $(shell cat $(FILELIST))
RTL_SRCS := $(filter design/%,$(ALL_SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'TEST RESULT: PASS' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/cla_adder.sv
// 28-bit add only, no carry in and no carry out; result wraps on overflow
`timescale 1ns/10ps

module cla_adder (
  input  mac_pkg::acc_t a,
  input  mac_pkg::acc_t b,
  output mac_pkg::acc_t s
);

  logic [mac_pkg::acc_w-1:0]   p;  // bit propagate
  logic [mac_pkg::acc_w-2:0]   g;  // bit generate, top bit would only feed the carry out
  logic [mac_pkg::acc_w-1:0]   c;  // carry into each bit
  logic [mac_pkg::acc_w/4-2:0] gp; // group propagate, groups 0..5
  logic [mac_pkg::acc_w/4-2:0] gg; // group generate, groups 0..5
  logic [mac_pkg::acc_w/4-1:0] gc; // carry into each 4-bit group

  assign p = a ^ b;
  assign g = a[mac_pkg::acc_w-2:0] & b[mac_pkg::acc_w-2:0];

  //////////////////////////////
  // first level, 4-bit groups
  //////////////////////////////
  for (genvar k = 0; k < mac_pkg::acc_w / 4 - 1; k++) begin : g_grp
    assign gp[k] = &p[4*k +: 4];
    assign gg[k] = g[4*k+3]
                 | (g[4*k+2] & p[4*k+3])
                 | (g[4*k+1] & p[4*k+2] & p[4*k+3])
                 | (g[4*k]   & p[4*k+1] & p[4*k+2] & p[4*k+3]);
  end

  //////////////////////////////
  // second level, group carries
  //////////////////////////////
  // each group carry is a flat sum of products, no ripple through lower groups
  always_comb begin : group_carry
    logic term;
    gc = '0;
    for (int k = 1; k < mac_pkg::acc_w / 4; k++) begin
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        gc[k] = gc[k] | term;
      end
    end
  end

  // carries inside a group start from its group carry
  always_comb begin
    for (int k = 0; k < mac_pkg::acc_w / 4; k++) begin
      c[4*k] = gc[k];
      for (int i = 1; i < 4; i++) begin
        c[4*k+i] = g[4*k+i-1] | (p[4*k+i-1] & c[4*k+i-1]);
      end
    end
  end

  assign s = p ^ c;

endmodule

//--- design/mac_decode.sv
// stage 1 of the multiplier; a and b are sampled only at edges with en high
`timescale 1ns/10ps

module mac_decode (
  input  logic                clk,
  input  logic                rstn,
  input  logic                en,
  input  mac_pkg::operand_t   a,
  input  mac_pkg::operand_t   b,
  input  logic                first,
  output mac_pkg::pp_stage_t  pp
);

  logic [mac_pkg::data_w-1:0] a_mag;  // 128 for -128, still fits unsigned
  logic [mac_pkg::data_w-1:0] b_mag;
  mac_pkg::pp_stage_t         pp_d;

  // two's complement magnitudes
  assign a_mag = a[mac_pkg::data_w-1] ? (~a + 1'b1) : a;
  assign b_mag = b[mac_pkg::data_w-1] ? (~b + 1'b1) : b;

  //////////////////////////////
  // partial products
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < mac_pkg::pp_n; i++) begin
      pp_d.part[i] = b_mag[i] ? a_mag : '0;  // weight 2^i applied later in the tree
    end
    pp_d.sign  = a[mac_pkg::data_w-1] ^ b[mac_pkg::data_w-1];
    pp_d.first = first;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pp <= '0;
    end else if (en) begin
      pp <= pp_d;
    end
  end

endmodule

//--- design/mac_execute.sv
// stages 2 to 8, fixed for 8 partial products of 8 bits; whole pipe holds when en is low
`timescale 1ns/10ps

module mac_execute (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 en,
  input  mac_pkg::pp_stage_t   pp,
  output mac_pkg::prod_stage_t prod
);

  // stage 2, pairs of partial products, low half
  logic [3:0][5:0]  lsb2_d, lsb2_q;
  logic [3:0][2:0]  msb2a_q;  // even pp bits 7:5
  logic [3:0][3:0]  msb2b_q;  // odd pp bits 7:4, already weighted by 2
  // stage 3, high half
  logic [3:0][4:0]  msb3;
  logic [3:0][9:0]  sum3_d, sum3_q;
  // stage 4, pairs of sums shifted by 2, low half
  logic [1:0][7:0]  lsb4_d, lsb4_q;
  logic [1:0][2:0]  msb4a_q;
  logic [1:0][4:0]  msb4b_q;
  // stage 5
  logic [1:0][4:0]  msb5;
  logic [1:0][11:0] sum5_d, sum5_q;
  // stage 6, last pair shifted by 4, low half
  logic [9:0]       lsb6_d, lsb6_q;
  logic [2:0]       msb6a_q;
  logic [6:0]       msb6b_q;
  // stage 7
  logic [6:0]       msb7;
  logic [15:0]      sum_u_d, sum_u_q;  // unsigned magnitude of the product

  logic [5:0]       sign_q;   // sign through stages 2..7
  logic [5:0]       first_q;  // first through stages 2..7

  //////////////////////////////
  // adder tree, combinational
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lsb2_d[i] = 6'(pp.part[2*i][4:0]) + {1'b0, pp.part[2*i+1][3:0], 1'b0};
      msb3[i]   = 5'(msb2a_q[i]) + 5'(msb2b_q[i]) + 5'(lsb2_q[i][5]); // carry from low half
      sum3_d[i] = {msb3[i], lsb2_q[i][4:0]};
    end
    for (int j = 0; j < 2; j++) begin
      lsb4_d[j] = 8'(sum3_q[2*j][6:0]) + {1'b0, sum3_q[2*j+1][4:0], 2'b00};
      msb5[j]   = 5'(msb4a_q[j]) + msb4b_q[j] + 5'(lsb4_q[j][7]);
      sum5_d[j] = {msb5[j], lsb4_q[j][6:0]};
    end
    lsb6_d  = 10'(sum5_q[0][8:0]) + {1'b0, sum5_q[1][4:0], 4'b0000};
    msb7    = 7'(msb6a_q) + msb6b_q + 7'(lsb6_q[9]);
    sum_u_d = {msb7, lsb6_q[8:0]};
  end

  //////////////////////////////
  // pipeline registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      lsb2_d_reset: begin
        lsb2_q  <= '0;
        msb2a_q <= '0;
        msb2b_q <= '0;
        sum3_q  <= '0;
        lsb4_q  <= '0;
        msb4a_q <= '0;
        msb4b_q <= '0;
        sum5_q  <= '0;
        lsb6_q  <= '0;
        msb6a_q <= '0;
        msb6b_q <= '0;
        sum_u_q <= '0;
        sign_q  <= '0;
        first_q <= '0;
        prod    <= '0;
      end
    end else if (en) begin
      lsb2_q <= lsb2_d;
      for (int i = 0; i < 4; i++) begin
        msb2a_q[i] <= pp.part[2*i][7:5];
        msb2b_q[i] <= pp.part[2*i+1][7:4];
      end
      sum3_q <= sum3_d;
      lsb4_q <= lsb4_d;
      for (int j = 0; j < 2; j++) begin
        msb4a_q[j] <= sum3_q[2*j][9:7];
        msb4b_q[j] <= sum3_q[2*j+1][9:5];
      end
      sum5_q  <= sum5_d;
      lsb6_q  <= lsb6_d;
      msb6a_q <= sum5_q[0][11:9];
      msb6b_q <= sum5_q[1][11:5];
      sum_u_q <= sum_u_d;
      sign_q  <= {sign_q[4:0], pp.sign};
      first_q <= {first_q[4:0], pp.first};
      // stage 8, sign restore
      prod.value <= sign_q[5] ? -mac_pkg::product_t'(sum_u_q) : mac_pkg::product_t'(sum_u_q);
      prod.first <= first_q[5];
    end
  end

  // magnitude out of the tree is bounded by |-128| * |-128|, so the tree drops no carry
  tree_range_a : assert property (
    @(posedge clk) disable iff (!rstn) en |=> (sum_u_q <= mac_pkg::mag_max)
  ) else $error("adder tree magnitude %0d above %0d", sum_u_q, mac_pkg::mag_max);

endmodule

//--- design/mac_pe.sv
// 9-stage signed MAC; a pair sampled at enabled edge n reaches acc at n+8 and q at n+9
`timescale 1ns/10ps

module mac_pe (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    en,     // low stalls every stage
  input  logic                    first,  // travels with a and b
  input  mac_pkg::operand_t       a,
  input  mac_pkg::operand_t       b,
  input  mac_pkg::operand_t       bias,
  output mac_pkg::acc_t           acc,
  output logic [mac_pkg::q_w-1:0] q
);

  mac_pkg::pp_stage_t   pp;   // stage 1 out
  mac_pkg::prod_stage_t prod; // stage 8 out

  mac_decode i_mac_decode (
    .clk   (clk),
    .rstn  (rstn),
    .en    (en),
    .a     (a),
    .b     (b),
    .first (first),
    .pp    (pp)
  );

  mac_execute i_mac_execute (
    .clk  (clk),
    .rstn (rstn),
    .en   (en),
    .pp   (pp),
    .prod (prod)
  );

  mac_result i_mac_result (
    .clk  (clk),
    .rstn (rstn),
    .en   (en),
    .prod (prod),
    .bias (bias),
    .acc  (acc),
    .q    (q)
  );

endmodule

//--- design/mac_pkg.sv
// signed 8-bit operands only; accumulator wraps silently past 28 bits, no overflow flag
package mac_pkg;

  //////////////////////////////
  // widths and limits
  //////////////////////////////
  localparam int unsigned data_w     = 8;      // operand width
  localparam int unsigned prod_w     = 16;     // full product width
  localparam int unsigned acc_w      = 28;     // accumulator width
  localparam int unsigned pp_n       = data_w; // one partial product per multiplier bit
  localparam int unsigned bias_shift = 6;      // bias is aligned to the fraction point
  localparam int unsigned q_max      = 127;    // saturated output code
  localparam int unsigned q_w        = 8;      // output byte, msb always zero
  localparam int unsigned mag_max    = 16384;  // -128 * -128

  //////////////////////////////
  // words
  //////////////////////////////
  typedef logic signed [data_w-1:0] operand_t;
  typedef logic signed [prod_w-1:0] product_t;
  typedef logic signed [acc_w-1:0]  acc_t;

  //////////////////////////////
  // stage payloads
  //////////////////////////////

  // leaves decode, 66 bits
  typedef struct packed {
    logic [pp_n-1:0][data_w-1:0] part;  // part[i] = |a| gated by bit i of |b|
    logic                        sign;  // product sign
    logic                        first; // restart accumulation with this pair
  } pp_stage_t;

  // leaves execute, 17 bits
  typedef struct packed {
    product_t value; // signed product
    logic     first;
  } prod_stage_t;

endpackage

//--- design/mac_result.sv
// stage 9 accumulate and requantize; q follows acc one enabled edge later with the bias of that edge
`timescale 1ns/10ps

module mac_result (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       en,
  input  mac_pkg::prod_stage_t       prod,
  input  mac_pkg::operand_t          bias,
  output mac_pkg::acc_t              acc,
  output logic [mac_pkg::q_w-1:0]    q
);

  mac_pkg::acc_t            prod_ext;  // product sign extended
  mac_pkg::acc_t            acc_base;  // zero when a new run starts
  mac_pkg::acc_t            acc_d;
  mac_pkg::acc_t            bias_ext;  // bias sign extended, shifted left by 6
  mac_pkg::acc_t            bias_sum;
  logic [mac_pkg::q_w-1:0]  q_d;

  //////////////////////////////
  // accumulate
  //////////////////////////////
  assign prod_ext = {{(mac_pkg::acc_w-mac_pkg::prod_w){prod.value[mac_pkg::prod_w-1]}},
                     prod.value};
  assign acc_base = prod.first ? '0 : acc;

  cla_adder accum_add (
    .a (prod_ext),
    .b (acc_base),
    .s (acc_d)
  );

  //////////////////////////////
  // bias and requantize
  //////////////////////////////
  assign bias_ext = {{(mac_pkg::acc_w-mac_pkg::data_w-mac_pkg::bias_shift){bias[mac_pkg::data_w-1]}},
                     bias, {mac_pkg::bias_shift{1'b0}}};

  cla_adder bias_add (
    .a (acc),
    .b (bias_ext),
    .s (bias_sum)
  );

  always_comb begin
    if (bias_sum[mac_pkg::acc_w-1]) begin
      q_d = '0;                                  // negative clamps to zero
    end else if (|bias_sum[mac_pkg::acc_w-2:mac_pkg::bias_shift+mac_pkg::q_w-1]) begin
      q_d = mac_pkg::q_w'(mac_pkg::q_max);       // 2^13 and above saturates
    end else begin
      q_d = mac_pkg::q_w'(bias_sum[mac_pkg::bias_shift+mac_pkg::q_w-2:mac_pkg::bias_shift]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc <= '0;
      q   <= '0;
    end else if (en) begin
      acc <= acc_d;
      q   <= q_d;
    end
  end

  // an X here would come from an unreset register further up the pipe
  acc_known_a : assert property (
    @(posedge clk) disable iff (!rstn) !$isunknown({acc, q})
  ) else $error("acc or q unknown after reset");

endmodule

//--- files.f
design/mac_pkg.sv
design/cla_adder.sv
design/mac_decode.sv
design/mac_execute.sv
design/mac_result.sv
design/mac_pe.sv
tb/tb_mac_pe.sv

//--- tb/tb_mac_pe.sv
// needs a simulator with timing support; the model counts enabled edges only and expects acc at n+8 and q at n+9
`timescale 1ns/10ps

module tb_mac_pe;

  typedef struct packed {
    mac_pkg::operand_t a;
    mac_pkg::operand_t b;
    logic              first;
  } sample_t;

  logic                    clk;
  logic                    rstn;
  logic                    en;
  logic                    first;
  mac_pkg::operand_t       a;
  mac_pkg::operand_t       b;
  mac_pkg::operand_t       bias;
  mac_pkg::acc_t           acc;
  logic [mac_pkg::q_w-1:0] q;

  integer seed       = 73;
  int     wait_limit = 64;      // cycles a pair may wait for en
  string  test_name  = "reset";
  logic   stall_on   = 1'b0;
  logic   check_on   = 1'b0;    // set once the first reset edge has passed

  // reference model state
  sample_t                 pending[$];  // pairs sampled but not yet in acc
  sample_t                 head;
  mac_pkg::acc_t           exp_acc = '0;
  logic [mac_pkg::q_w-1:0] exp_q   = '0;
  longint                  sum_v;
  int neg_hits = 0;
  int mid_hits = 0;
  int sat_hits = 0;

  int acc_errors     = 0;
  int q_errors       = 0;
  int reset_errors   = 0;
  int stall_errors   = 0;
  int check_errors   = 0;
  int timeout_errors = 0;
  int cover_errors   = 0;

  mac_pe i_mac_pe (
    .clk   (clk),
    .rstn  (rstn),
    .en    (en),
    .first (first),
    .a     (a),
    .b     (b),
    .bias  (bias),
    .acc   (acc),
    .q     (q)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic longint product(input sample_t s);
    return longint'(s.a) * longint'(s.b);
  endfunction

  function automatic longint biased_sum(input mac_pkg::acc_t acc_v,
                                        input mac_pkg::operand_t bias_v);
    return longint'(acc_v) + (longint'(bias_v) * (longint'(1) << mac_pkg::bias_shift));
  endfunction

  function automatic logic [mac_pkg::q_w-1:0] clamp_q(input longint s);
    if (s < 0) begin
      return '0;
    end
    if (s >= (longint'(mac_pkg::q_max + 1) << mac_pkg::bias_shift)) begin  // 2^13
      return mac_pkg::q_w'(mac_pkg::q_max);
    end
    return mac_pkg::q_w'(s >>> mac_pkg::bias_shift);
  endfunction

  always @(posedge clk) begin
    if (!rstn) begin
      pending.delete();
      exp_acc  <= '0;
      exp_q    <= '0;
      check_on <= 1'b1;
    end else if (en) begin
      sum_v = biased_sum(exp_acc, bias);  // acc before this edge, bias at this edge
      exp_q <= clamp_q(sum_v);
      if (sum_v < 0) begin
        neg_hits++;
      end else if (sum_v >= 8192) begin
        sat_hits++;
      end else begin
        mid_hits++;
      end
      if (pending.size() == 8) begin  // eight enabled edges after sampling
        head = pending.pop_front();
        if (head.first) begin
          exp_acc <= mac_pkg::acc_t'(product(head));
        end else begin
          exp_acc <= exp_acc + mac_pkg::acc_t'(product(head));
        end
      end
      pending.push_back(sample_t'({a, b, first}));
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////
  acc_model_a : assert property (@(posedge clk) disable iff (!check_on) acc == exp_acc)
    else begin
      acc_errors++;
      $display("MISMATCH %s acc expected %0d actual %0d", test_name, $sampled(exp_acc),
               $sampled(acc));
    end

  q_model_a : assert property (@(posedge clk) disable iff (!check_on) q == exp_q)
    else begin
      q_errors++;
      $display("MISMATCH %s q expected %0d actual %0d", test_name, $sampled(exp_q), $sampled(q));
    end

  reset_zero_a : assert property (@(posedge clk) disable iff (!check_on)
                                  !rstn |-> (acc == '0 && q == '0))
    else begin
      reset_errors++;
      $display("MISMATCH %s acc,q expected 0,0 actual %0d,%0d", test_name, $sampled(acc),
               $sampled(q));
    end

  // held pipeline means both outputs freeze for the stalled edge
  stall_hold_a : assert property (@(posedge clk) disable iff (!check_on)
                                  (rstn && !en) |=> ($stable(acc) && $stable(q)))
    else begin
      stall_errors++;
      $display("acc or q changed while en was low in %s", test_name);
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  function automatic logic pick_en();
    if (!stall_on) begin
      return 1'b1;
    end
    return ($random(seed) & 3) != 0;  // about one stall in four
  endfunction

  function automatic mac_pkg::operand_t rand_operand();
    return mac_pkg::operand_t'($random(seed));
  endfunction

  // holds the pair on the inputs until an edge with en high takes it
  task automatic send_pair(input mac_pkg::operand_t a_v, input mac_pkg::operand_t b_v,
                           input logic first_v, input mac_pkg::operand_t bias_v);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    a      = a_v;
    b      = b_v;
    first  = first_v;
    bias   = bias_v;
    while (!taken && waited < wait_limit) begin
      en = pick_en();
      @(posedge clk);
      #1;
      taken = en;
      waited++;
    end
    if (!taken) begin
      timeout_errors++;
      $display("pair %0d x %0d was not taken within %0d cycles in %s", a_v, b_v, wait_limit,
               test_name);
    end
  endtask

  task automatic flush_pipe(input int n, input mac_pkg::operand_t bias_v);
    repeat (n) send_pair('0, '0, 1'b0, bias_v);  // zero pairs add nothing
  endtask

  task automatic run_accum(input int len);
    longint            run_sum;
    mac_pkg::operand_t a_v;
    mac_pkg::operand_t b_v;
    run_sum = 0;
    for (int i = 0; i < len; i++) begin
      a_v = rand_operand();
      b_v = rand_operand();
      run_sum += longint'(a_v) * longint'(b_v);
      send_pair(a_v, b_v, i == 0, rand_operand());
    end
    flush_pipe(8, rand_operand());
    assert (acc == mac_pkg::acc_t'(run_sum)) else begin
      check_errors++;
      $display("MISMATCH %s run of %0d expected %0d actual %0d", test_name, len, run_sum, acc);
    end
  endtask

  task automatic check_quant(input mac_pkg::operand_t a_v, input mac_pkg::operand_t b_v,
                             input mac_pkg::operand_t bias_v,
                             input logic [mac_pkg::q_w-1:0] q_exp);
    send_pair(a_v, b_v, 1'b1, bias_v);
    flush_pipe(9, bias_v);
    assert (q == q_exp) else begin
      check_errors++;
      $display("MISMATCH %s %0d x %0d bias %0d expected %0d actual %0d", test_name, a_v, b_v,
               bias_v, q_exp, q);
    end
  endtask

  initial begin
    int run_len;
    int total;
    rstn  = 1'b0;
    en    = 1'b0;
    first = 1'b0;
    a     = '0;
    b     = '0;
    bias  = '0;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    flush_pipe(10, '0);

    test_name = "single";
    send_pair(8'sh80, 8'sh80, 1'b1, 8'sd0);  // -128 x -128
    send_pair(8'sh80, 8'sd127, 1'b1, 8'sd0);
    send_pair(8'sd127, 8'sh80, 1'b1, 8'sd0);
    send_pair(8'sd0, rand_operand(), 1'b1, 8'sd0);
    send_pair(rand_operand(), 8'sd0, 1'b1, 8'sd0);
    send_pair(8'sd127, 8'sd127, 1'b1, 8'sd0);
    send_pair(-8'sd1, -8'sd1, 1'b1, 8'sd0);
    repeat (40) send_pair(rand_operand(), rand_operand(), 1'b1, rand_operand());
    flush_pipe(9, '0);

    test_name = "accumulate";
    repeat (25) begin
      run_len = 1 + (($random(seed) & 255) % 20);
      run_accum(run_len);
    end

    test_name = "stall";
    stall_on  = 1'b1;
    repeat (15) begin
      run_len = 1 + (($random(seed) & 255) % 20);
      run_accum(run_len);
    end
    stall_on = 1'b0;

    test_name = "requantize";
    check_quant(8'sd10, 8'sd10, 8'sh80, 8'd0);      // 100 - 8192 is negative
    check_quant(8'sd100, 8'sd50, 8'sd10, 8'd88);    // 5640 / 64
    check_quant(8'sh80, 8'sh80, 8'sd0, 8'd127);     // 16384 saturates
    check_quant(-8'sd100, 8'sd50, 8'sd127, 8'd48);  // -5000 + 8128
    check_quant(8'sd127, 8'sd64, 8'sd1, 8'd127);    // exactly 2^13
    check_quant(8'sd127, 8'sd64, 8'sd0, 8'd127);    // 8128 is the top of the range
    check_quant(-8'sd1, 8'sd1, 8'sd0, 8'd0);
    check_quant(8'sd63, 8'sd1, 8'sd0, 8'd0);        // rounds down
    repeat (40) send_pair(rand_operand(), rand_operand(), 1'b1, rand_operand());
    flush_pipe(9, rand_operand());
    en = 1'b0;
    @(posedge clk);
    #1;

    if (neg_hits == 0 || mid_hits == 0 || sat_hits == 0) begin
      cover_errors++;
      $display("requantize ranges not all reached: negative %0d, in range %0d, saturated %0d",
               neg_hits, mid_hits, sat_hits);
    end
    total = acc_errors + q_errors + reset_errors + stall_errors + check_errors
          + timeout_errors + cover_errors;
    $display("errors: acc %0d, q %0d, reset %0d, stall %0d, checks %0d, timeouts %0d, ranges %0d",
             acc_errors, q_errors, reset_errors, stall_errors, check_errors, timeout_errors,
             cover_errors);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
